// ==== design/rv_core_macros.svh ====
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// machine word width
`define XLEN 32

// architectural register count, x0 included
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== design/rv_core_pkg.sv ====
`include "rv_core_macros.svh"

package rv_core_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111
    } opcode_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        logic [31:0] inst;
    } inst_resp_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        opcode_t    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] funct3;
        logic [6:0] funct7;
        word_t      imm;
        word_t      rs1_value;
        word_t      rs2_value;
    } dec_exe_t;

    typedef struct packed {
        logic       valid;
        reg_idx_t   rd;
        word_t      result;
        logic       load;
        logic       store;
        logic [2:0] funct3;
        word_t      addr;
        word_t      store_data;
    } exe_mem_t;

    // word addressed, strobes select bytes
    typedef struct packed {
        logic                 rden;
        logic                 wren;
        logic [`XLEN-3:0]     addr;
        logic [`XLEN/8-1:0]   strb;
        word_t                wdata;
    } data_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

// ==== design/fetch.sv ====
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_wait,
    input  logic                   hold,
    input  rv_core_pkg::redirect_t redirect,
    output logic                   inst_rden,
    output rv_core_pkg::word_t     inst_raddr
);

    rv_core_pkg::word_t pc;
    logic               rden;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= `RESET_PC;
            rden <= 1'b0;
        end else if (!mem_wait) begin
            rden <= 1'b1;
            if (redirect.taken) begin
                pc <= redirect.target;
            end else if (rden && !hold) begin
                pc <= pc + rv_core_pkg::word_t'(4);
            end
            // held or first request keeps the same address
        end
    end

    assign inst_rden  = rden;
    assign inst_raddr = pc;

endmodule

// ==== design/decode.sv ====
`timescale 1ns/1ps

module decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mem_wait,
    input  rv_core_pkg::inst_resp_t inst_resp,
    input  rv_core_pkg::redirect_t  redirect,
    input  rv_core_pkg::dec_exe_t   exe_in,
    input  rv_core_pkg::word_t      rs1_value,
    input  rv_core_pkg::word_t      rs2_value,
    output rv_core_pkg::reg_idx_t   rs1,
    output rv_core_pkg::reg_idx_t   rs2,
    output logic                    hold,
    output rv_core_pkg::dec_exe_t   dec_out
);

    rv_core_pkg::inst_resp_t cur;
    rv_core_pkg::inst_resp_t replay_resp;
    rv_core_pkg::opcode_t    opcode;
    rv_core_pkg::dec_exe_t   next;
    rv_core_pkg::word_t      imm;
    logic [31:0]             inst;
    logic                    replay;
    logic                    kill;
    logic                    known;
    logic                    uses_rs1;
    logic                    uses_rs2;
    logic                    has_rd;

    // a held instruction comes back from the replay register
    assign cur    = replay ? replay_resp : inst_resp;
    assign inst   = cur.inst;
    assign opcode = rv_core_pkg::opcode_t'(inst[6:0]);

    always_comb begin
        known    = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        has_rd   = 1'b1;
        case (opcode)
            rv_core_pkg::opc_lui, rv_core_pkg::opc_auipc, rv_core_pkg::opc_jal: uses_rs1 = 1'b0;
            rv_core_pkg::opc_jalr, rv_core_pkg::opc_load, rv_core_pkg::opc_op_imm: known = 1'b1;
            rv_core_pkg::opc_op: uses_rs2 = 1'b1;
            rv_core_pkg::opc_branch, rv_core_pkg::opc_store: begin
                uses_rs2 = 1'b1;
                has_rd   = 1'b0;
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_core_pkg::opc_store:
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_core_pkg::opc_branch:
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_core_pkg::opc_lui, rv_core_pkg::opc_auipc:
                imm = {inst[31:12], 12'b0};
            rv_core_pkg::opc_jal:
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

    assign rs1 = uses_rs1 ? inst[19:15] : '0;
    assign rs2 = uses_rs2 ? inst[24:20] : '0;

    // load-use interlock against the record now in execute
    assign hold = cur.valid && known && !kill && exe_in.valid
                  && exe_in.opcode == rv_core_pkg::opc_load && exe_in.rd != '0
                  && (rs1 == exe_in.rd || rs2 == exe_in.rd);

    always_comb begin
        next           = '0;
        next.valid     = cur.valid && known && !kill && !redirect.taken && !hold;
        next.pc        = cur.pc;
        next.opcode    = opcode;
        next.rd        = has_rd ? inst[11:7] : '0;
        next.rs1       = rs1;
        next.rs2       = rs2;
        next.funct3    = inst[14:12];
        next.funct7    = inst[31:25];
        next.imm       = imm;
        next.rs1_value = rs1_value;
        next.rs2_value = rs2_value;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_out.valid <= 1'b0;
            kill          <= 1'b0;
            replay        <= 1'b0;
        end else if (!mem_wait) begin
            dec_out <= next;
            // second younger instruction still in flight from memory
            kill    <= redirect.taken;
            replay  <= hold;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_wait && hold) begin
            replay_resp <= cur;
        end
    end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module register_file (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_core_pkg::reg_idx_t rs1,
    input  rv_core_pkg::reg_idx_t rs2,
    input  rv_core_pkg::wb_t      wb,
    output rv_core_pkg::word_t    rs1_value,
    output rv_core_pkg::word_t    rs2_value
);

    // x0 has no storage
    rv_core_pkg::word_t regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write wins
    assign rs1_value = (rs1 == '0) ? '0 :
                       (wb.valid && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 :
                       (wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

// ==== design/exec.sv ====
`timescale 1ns/1ps

module exec (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_wait,
    input  rv_core_pkg::dec_exe_t  dec_in,
    input  rv_core_pkg::exe_mem_t  fwd_mem,
    input  rv_core_pkg::wb_t       fwd_wb,
    output rv_core_pkg::redirect_t redirect,
    output rv_core_pkg::exe_mem_t  exe_out
);

    rv_core_pkg::word_t    a;
    rv_core_pkg::word_t    b;
    rv_core_pkg::word_t    op_b;
    rv_core_pkg::word_t    alu;
    rv_core_pkg::word_t    addr_sum;
    rv_core_pkg::word_t    result;
    rv_core_pkg::exe_mem_t next;
    logic [4:0]            shamt;
    logic                  sub;
    logic                  eq;
    logic                  lt;
    logic                  ltu;
    logic                  cond;

    // memory stage first, then writeback
    function automatic rv_core_pkg::word_t pick(
        input rv_core_pkg::reg_idx_t idx,
        input rv_core_pkg::word_t    reg_value,
        input rv_core_pkg::exe_mem_t mem,
        input rv_core_pkg::wb_t      wb
    );
        if (idx != '0 && mem.valid && !mem.load && mem.rd == idx) begin
            return mem.result;
        end
        if (wb.valid && wb.rd == idx) begin
            return wb.data;
        end
        return reg_value;
    endfunction

    assign a = pick(dec_in.rs1, dec_in.rs1_value, fwd_mem, fwd_wb);
    assign b = pick(dec_in.rs2, dec_in.rs2_value, fwd_mem, fwd_wb);

    assign op_b  = (dec_in.opcode == rv_core_pkg::opc_op) ? b : dec_in.imm;
    assign shamt = op_b[4:0];
    assign sub   = dec_in.opcode == rv_core_pkg::opc_op && dec_in.funct7[5];

    always_comb begin
        case (dec_in.funct3)
            3'b000:  alu = sub ? a - op_b : a + op_b;
            3'b001:  alu = a << shamt;
            3'b010:  alu = rv_core_pkg::word_t'($signed(a) < $signed(op_b));
            3'b011:  alu = rv_core_pkg::word_t'(a < op_b);
            3'b100:  alu = a ^ op_b;
            3'b101: begin
                if (dec_in.funct7[5]) begin
                    alu = $signed(a) >>> shamt;
                end else begin
                    alu = a >> shamt;
                end
            end
            3'b110:  alu = a | op_b;
            default: alu = a & op_b;
        endcase
    end

    assign addr_sum = a + dec_in.imm;

    always_comb begin
        case (dec_in.opcode)
            rv_core_pkg::opc_lui:   result = dec_in.imm;
            rv_core_pkg::opc_auipc: result = dec_in.pc + dec_in.imm;
            rv_core_pkg::opc_jal,
            rv_core_pkg::opc_jalr:  result = dec_in.pc + rv_core_pkg::word_t'(4);
            default:                result = alu;
        endcase
    end

    // branch compare always on the two registers
    assign eq  = a == b;
    assign lt  = $signed(a) < $signed(b);
    assign ltu = a < b;

    always_comb begin
        case (dec_in.funct3)
            3'b000:  cond = eq;
            3'b001:  cond = !eq;
            3'b100:  cond = lt;
            3'b101:  cond = !lt;
            3'b110:  cond = ltu;
            3'b111:  cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        redirect.taken  = 1'b0;
        redirect.target = dec_in.pc + dec_in.imm;
        if (dec_in.valid) begin
            case (dec_in.opcode)
                rv_core_pkg::opc_jal:    redirect.taken = 1'b1;
                rv_core_pkg::opc_branch: redirect.taken = cond;
                rv_core_pkg::opc_jalr: begin
                    redirect.taken  = 1'b1;
                    redirect.target = {addr_sum[31:1], 1'b0};
                end
                default: redirect.taken = 1'b0;
            endcase
        end
    end

    always_comb begin
        next            = '0;
        next.valid      = dec_in.valid;
        next.rd         = dec_in.rd;
        next.result     = result;
        next.load       = dec_in.opcode == rv_core_pkg::opc_load;
        next.store      = dec_in.opcode == rv_core_pkg::opc_store;
        next.funct3     = dec_in.funct3;
        next.addr       = addr_sum;
        next.store_data = b;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_out.valid <= 1'b0;
        end else if (!mem_wait) begin
            exe_out <= next;
        end
    end

endmodule

// ==== design/mem_access.sv ====
`timescale 1ns/1ps

module mem_access (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_wait,
    input  rv_core_pkg::exe_mem_t  exe_in,
    input  rv_core_pkg::word_t     data_rdata,
    output rv_core_pkg::data_req_t data_req,
    output rv_core_pkg::wb_t       wb
);

    rv_core_pkg::wb_t   wb_q;
    rv_core_pkg::word_t shifted;
    rv_core_pkg::word_t load_value;
    logic               ld_q;
    logic [2:0]         ld_funct3;
    logic [1:0]         ld_off;
    logic [3:0]         strb;
    logic [1:0]         off;

    assign off = exe_in.addr[1:0];

    always_comb begin
        case (exe_in.funct3[1:0])
            2'b00:   strb = 4'b0001 << off;
            2'b01:   strb = 4'b0011 << {off[1], 1'b0};
            default: strb = 4'b1111;
        endcase
    end

    assign data_req.rden = exe_in.valid && exe_in.load;
    assign data_req.wren = exe_in.valid && exe_in.store;
    assign data_req.addr = exe_in.addr[31:2];
    assign data_req.strb = data_req.wren ? strb : 4'b0000;

    // replicate so the strobed lanes carry the data
    always_comb begin
        case (exe_in.funct3[1:0])
            2'b00:   data_req.wdata = {4{exe_in.store_data[7:0]}};
            2'b01:   data_req.wdata = {2{exe_in.store_data[15:0]}};
            default: data_req.wdata = exe_in.store_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q.valid <= 1'b0;
            ld_q       <= 1'b0;
        end else if (!mem_wait) begin
            wb_q.valid <= exe_in.valid && exe_in.rd != '0;
            wb_q.rd    <= exe_in.rd;
            wb_q.data  <= exe_in.result;
            ld_q       <= exe_in.valid && exe_in.load;
            ld_funct3  <= exe_in.funct3;
            ld_off     <= off;
        end
    end

    // load data lands one cycle after the read
    assign shifted = data_rdata >> {ld_off, 3'b000};

    always_comb begin
        case (ld_funct3)
            3'b000:  load_value = {{24{shifted[7]}}, shifted[7:0]};
            3'b001:  load_value = {{16{shifted[15]}}, shifted[15:0]};
            3'b100:  load_value = {24'b0, shifted[7:0]};
            3'b101:  load_value = {16'b0, shifted[15:0]};
            default: load_value = shifted;
        endcase
    end

    assign wb.valid = wb_q.valid;
    assign wb.rd    = wb_q.rd;
    assign wb.data  = ld_q ? load_value : wb_q.data;

endmodule

// ==== design/core.sv ====
`timescale 1ns/1ps

module core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mem_wait,
    input  rv_core_pkg::inst_resp_t inst_resp,
    input  rv_core_pkg::word_t      data_rdata,
    output logic                    inst_rden,
    output rv_core_pkg::word_t      inst_raddr,
    output rv_core_pkg::data_req_t  data_req,
    output rv_core_pkg::wb_t        wb
);

    rv_core_pkg::redirect_t redirect;
    rv_core_pkg::dec_exe_t  dec_out;
    rv_core_pkg::exe_mem_t  exe_out;
    rv_core_pkg::reg_idx_t  rs1;
    rv_core_pkg::reg_idx_t  rs2;
    rv_core_pkg::word_t     rs1_value;
    rv_core_pkg::word_t     rs2_value;
    logic                   hold;

    fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .mem_wait   (mem_wait),
        .hold       (hold),
        .redirect   (redirect),
        .inst_rden  (inst_rden),
        .inst_raddr (inst_raddr)
    );

    // instruction response goes straight into decode
    decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .mem_wait   (mem_wait),
        .inst_resp  (inst_resp),
        .redirect   (redirect),
        .exe_in     (dec_out),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .rs1        (rs1),
        .rs2        (rs2),
        .hold       (hold),
        .dec_out    (dec_out)
    );

    register_file u_register_file (
        .clk        (clk),
        .rst        (rst),
        .rs1        (rs1),
        .rs2        (rs2),
        .wb         (wb),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value)
    );

    exec u_exec (
        .clk        (clk),
        .rst        (rst),
        .mem_wait   (mem_wait),
        .dec_in     (dec_out),
        .fwd_mem    (exe_out),
        .fwd_wb     (wb),
        .redirect   (redirect),
        .exe_out    (exe_out)
    );

    mem_access u_mem_access (
        .clk        (clk),
        .rst        (rst),
        .mem_wait   (mem_wait),
        .exe_in     (exe_out),
        .data_rdata (data_rdata),
        .data_req   (data_req),
        .wb         (wb)
    );

endmodule

// ==== verification/core_assert.sv ====
`timescale 1ns/1ps

module core_assert (
    input logic                   clk,
    input logic                   rst,
    input logic                   mem_wait,
    input rv_core_pkg::word_t     inst_raddr,
    input rv_core_pkg::data_req_t data_req,
    input rv_core_pkg::wb_t       wb
);

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
        wb.valid |-> wb.rd != '0)
        else $error("write-back to x0");

    store_has_strobes: assert property (@(posedge clk) disable iff (rst)
        data_req.wren |-> data_req.strb != '0)
        else $error("store without byte strobes");

    read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(data_req.rden && data_req.wren))
        else $error("data read and write in the same cycle");

    // stalled fetch keeps its address
    raddr_stable_in_wait: assert property (@(posedge clk) disable iff (rst)
        mem_wait |=> $stable(inst_raddr))
        else $error("instruction address moved during a stall");

endmodule

bind core core_assert u_core_assert (
    .clk        (clk),
    .rst        (rst),
    .mem_wait   (mem_wait),
    .inst_raddr (inst_raddr),
    .data_req   (data_req),
    .wb         (wb)
);

// ==== verification/core_tb.sv ====
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module core_tb;

    localparam int PROG_LEN  = 200;
    localparam int IMEM_WORDS = 256;
    localparam int DATA_WORDS = 64;
    localparam int DATA_WORD0 = 1024;
    localparam int CYCLE_LIMIT = 20 * PROG_LEN;

    logic                    clk;
    logic                    rst;
    logic                    mem_wait;
    rv_core_pkg::inst_resp_t inst_resp;
    rv_core_pkg::word_t      data_rdata;
    logic                    inst_rden;
    rv_core_pkg::word_t      inst_raddr;
    rv_core_pkg::data_req_t  data_req;
    rv_core_pkg::wb_t        wb;

    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [31:0] dmem [0:DATA_WORDS-1];
    logic [31:0] mdmem [0:DATA_WORDS-1];
    logic [31:0] regs [0:31];
    logic [31:0] lcg_state;
    rv_core_pkg::wb_t       exp_wb [$];
    rv_core_pkg::data_req_t exp_st [$];
    logic [31:0] final_pc;
    int          cycles;
    int          wb_count;
    int          st_count;
    int          settle;
    logic        done;

    core dut (
        .clk        (clk),
        .rst        (rst),
        .mem_wait   (mem_wait),
        .inst_resp  (inst_resp),
        .data_rdata (data_rdata),
        .inst_rden  (inst_rden),
        .inst_raddr (inst_raddr),
        .data_req   (data_req),
        .wb         (wb)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    task automatic stop_on_error(input string why);
        if (why != "") begin
            $display("%s", why);
        end
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_wb(input string name, input rv_core_pkg::wb_t exp,
                            input rv_core_pkg::wb_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_on_error("");
        end
    endtask

    // only the strobed byte lanes carry data
    task automatic check_store(input string name, input rv_core_pkg::data_req_t exp,
                               input rv_core_pkg::data_req_t act);
        rv_core_pkg::data_req_t e;
        rv_core_pkg::data_req_t a;
        e = exp;
        a = act;
        for (int i = 0; i < 4; i++) begin
            if (!exp.strb[i]) begin
                e.wdata[8*i +: 8] = 8'h00;
                a.wdata[8*i +: 8] = 8'h00;
            end
        end
        if (a !== e) begin
            $display("MISMATCH %s expected %h actual %h", name, e, a);
            stop_on_error("");
        end
    endtask

    function automatic logic [31:0] fill_word(input int word_addr);
        logic [31:0] a;
        a = 32'(word_addr);
        return (a * 32'h9e37_79b1) ^ (a << 16) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // rd from x2..x9 and sources from x0..x9 so hazards come often
    task automatic build_program();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        int          skip;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = 32'h0000_0013;
        end
        imem[0] = {20'h00001, 5'd1, 7'h37};
        for (int i = 1; i < PROG_LEN - 1; i++) begin
            r    = lcg_next();
            rd   = 5'(2 + (lcg_next() % 8));
            rs1  = 5'(lcg_next() % 10);
            rs2  = 5'(lcg_next() % 10);
            f3   = 3'(lcg_next());
            imm  = 12'(lcg_next());
            skip = 1 + (lcg_next() % 4);
            if (i + skip > PROG_LEN - 1) begin
                skip = PROG_LEN - 1 - i;
            end
            case (r % 16)
                0, 1, 2, 3: begin
                    f7 = ((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00;
                    imem[i] = {f7, rs2, rs1, f3, rd, 7'h33};
                end
                4, 5, 6: begin
                    if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
                    if (f3 == 3'd5) imm = {imm[10] ? 7'h20 : 7'h00, imm[4:0]};
                    imem[i] = enc_i(imm, rs1, f3, rd, 7'h13);
                end
                7:  imem[i] = {lcg_next() & 32'hffff_f000} | {20'h0, rd, 7'h37};
                8:  imem[i] = {lcg_next() & 32'hffff_f000} | {20'h0, rd, 7'h17};
                9, 10: begin
                    case (lcg_next() % 5)
                        0: f3 = 3'd0;
                        1: f3 = 3'd1;
                        2: f3 = 3'd2;
                        3: f3 = 3'd4;
                        default: f3 = 3'd5;
                    endcase
                    imm = 12'(lcg_next() % 256) & ~12'((1 << f3[1:0]) - 1);
                    imem[i] = enc_i(imm, 5'd1, f3, rd, 7'h03);
                end
                11, 12: begin
                    f3  = 3'(lcg_next() % 3);
                    imm = 12'(lcg_next() % 256) & ~12'((1 << f3[1:0]) - 1);
                    imem[i] = {imm[11:5], rs2, 5'd1, f3, imm[4:0], 7'h23};
                end
                13: begin
                    if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;
                    imem[i] = enc_b(13'(4 * skip), rs2, rs1, f3);
                end
                14: imem[i] = enc_j(21'(4 * skip), rd);
                // absolute target through x0
                default: imem[i] = enc_i(12'(4 * (i + skip)), 5'd0, 3'd0, rd, 7'h67);
            endcase
        end
        final_pc = 32'(4 * (PROG_LEN - 1));
        imem[PROG_LEN - 1] = enc_j(21'd0, 5'd0);
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] value);
        rv_core_pkg::wb_t rec;
        if (rd != 5'd0) begin
            regs[rd]  = value;
            rec.valid = 1'b1;
            rec.rd    = rd;
            rec.data  = value;
            exp_wb.push_back(rec);
        end
    endtask

    // ISA reference run producing the expected streams
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] in;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] imm_i;
        logic [2:0]  f3;
        logic        cond;
        int          idx;
        int          steps;
        rv_core_pkg::data_req_t st;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc    = `RESET_PC;
        steps = 0;
        while (pc != final_pc && steps < 10 * PROG_LEN) begin
            in    = imem[pc[31:2]];
            f3    = in[14:12];
            a     = regs[in[19:15]];
            b     = regs[in[24:20]];
            imm_i = {{20{in[31]}}, in[31:20]};
            res   = '0;
            steps++;
            case (in[6:0])
                7'h33, 7'h13: begin
                    if (in[6:0] == 7'h13) b = imm_i;
                    case (f3)
                        3'd0: res = (in[5] && in[30]) ? a - b : a + b;
                        3'd1: res = a << b[4:0];
                        3'd2: res = 32'($signed(a) < $signed(b));
                        3'd3: res = 32'(a < b);
                        3'd4: res = a ^ b;
                        3'd5: res = in[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                    write_reg(in[11:7], res);
                    pc = pc + 4;
                end
                7'h37: begin
                    write_reg(in[11:7], {in[31:12], 12'h0});
                    pc = pc + 4;
                end
                7'h17: begin
                    write_reg(in[11:7], pc + {in[31:12], 12'h0});
                    pc = pc + 4;
                end
                7'h03: begin
                    addr = a + imm_i;
                    word = mdmem[int'(addr[31:2]) - DATA_WORD0] >> (8 * addr[1:0]);
                    case (f3)
                        3'd0: res = {{24{word[7]}}, word[7:0]};
                        3'd1: res = {{16{word[15]}}, word[15:0]};
                        3'd4: res = {24'h0, word[7:0]};
                        3'd5: res = {16'h0, word[15:0]};
                        default: res = word;
                    endcase
                    write_reg(in[11:7], res);
                    pc = pc + 4;
                end
                7'h23: begin
                    addr     = a + {{20{in[31]}}, in[31:25], in[11:7]};
                    idx      = int'(addr[31:2]) - DATA_WORD0;
                    st       = '0;
                    st.wren  = 1'b1;
                    st.addr  = addr[31:2];
                    st.strb  = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
                    st.strb  = st.strb << addr[1:0];
                    st.wdata = b << (8 * addr[1:0]);
                    for (int k = 0; k < 4; k++) begin
                        if (st.strb[k]) mdmem[idx][8*k +: 8] = st.wdata[8*k +: 8];
                    end
                    exp_st.push_back(st);
                    pc = pc + 4;
                end
                7'h63: begin
                    case (f3)
                        3'd0: cond = a == b;
                        3'd1: cond = a != b;
                        3'd4: cond = $signed(a) < $signed(b);
                        3'd5: cond = $signed(a) >= $signed(b);
                        3'd6: cond = a < b;
                        default: cond = a >= b;
                    endcase
                    pc = cond ? pc + {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0}
                              : pc + 4;
                end
                7'h6f: begin
                    write_reg(in[11:7], pc + 4);
                    pc = pc + {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
                end
                default: begin
                    res = (a + imm_i) & ~32'h1;
                    write_reg(in[11:7], pc + 4);
                    pc = res;
                end
            endcase
        end
    endtask

    // sample mid-cycle, update memory inputs just after the edge
    initial begin : memory_and_monitor
        logic                   rden_s;
        logic                   mw_s;
        logic                   rst_s;
        logic                   checked_reset;
        logic                   first_seen;
        rv_core_pkg::word_t     raddr_s;
        rv_core_pkg::data_req_t req_s;
        int                     idx;
        checked_reset = 1'b0;
        first_seen    = 1'b0;
        forever begin
            @(negedge clk);
            rden_s  = inst_rden;
            raddr_s = inst_raddr;
            req_s   = data_req;
            mw_s    = mem_wait;
            rst_s   = rst;
            if (!rst) begin
                if (!checked_reset) begin
                    checked_reset = 1'b1;
                    if (inst_rden || wb.valid || data_req.rden || data_req.wren) begin
                        stop_on_error("outputs active in the first cycle after reset");
                    end
                end
                if (rden_s && !first_seen) begin
                    first_seen = 1'b1;
                    if (raddr_s !== `RESET_PC) begin
                        $display("MISMATCH first fetch expected %h actual %h",
                                 `RESET_PC, raddr_s);
                        stop_on_error("");
                    end
                end
                if (wb.valid && !mw_s) begin
                    if (exp_wb.size() == 0) stop_on_error("write-back with no expected record");
                    check_wb($sformatf("wb %0d", wb_count), exp_wb.pop_front(), wb);
                    wb_count++;
                end
                if (req_s.wren && !mw_s) begin
                    if (exp_st.size() == 0) stop_on_error("store with no expected record");
                    check_store($sformatf("store %0d", st_count), exp_st.pop_front(), req_s);
                    st_count++;
                end
                if (exp_wb.size() == 0 && exp_st.size() == 0 && raddr_s == final_pc) begin
                    settle++;
                end
                if (settle >= 10) done = 1'b1;
            end
            @(posedge clk);
            #2;
            if (!mw_s) begin
                inst_resp.valid <= rden_s;
                inst_resp.pc    <= raddr_s;
                inst_resp.inst  <= (raddr_s[31:2] < IMEM_WORDS) ? imem[raddr_s[31:2]]
                                                                 : 32'h0000_0013;
                if (!rst_s && (req_s.rden || req_s.wren)) begin
                    idx = int'(req_s.addr) - DATA_WORD0;
                    if (idx < 0 || idx >= DATA_WORDS) begin
                        stop_on_error("data access outside the data area");
                    end
                    if (req_s.rden) data_rdata <= dmem[idx];
                    for (int k = 0; k < 4; k++) begin
                        if (req_s.wren && req_s.strb[k]) begin
                            dmem[idx][8*k +: 8] = req_s.wdata[8*k +: 8];
                        end
                    end
                end
            end
            mem_wait <= !rst_s && (lcg_next() % 5 == 0);
            cycles++;
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        mem_wait   = 1'b0;
        inst_resp  = '0;
        data_rdata = '0;
        lcg_state  = 32'd2;
        cycles     = 0;
        wb_count   = 0;
        st_count   = 0;
        settle     = 0;
        done       = 1'b0;
        for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i]  = fill_word(DATA_WORD0 + i);
            mdmem[i] = dmem[i];
        end
        build_program();
        run_model();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        while (!done && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
        end
        if (done) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_on_error("program did not finish within the cycle limit");
        end
    end

endmodule

// ==== rv_core.f ====
+incdir+design
design/rv_core_pkg.sv
design/fetch.sv
design/decode.sv
design/register_file.sv
design/exec.sv
design/mem_access.sv
design/core.sv
verification/core_assert.sv
verification/core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the core testbench with Verilator and runs it.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f rv_core.f \
    --top-module core_tb \
    -o core_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/core_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
